// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  //--------------------------------------------------------------------------
  // Widths with a meaning
  //--------------------------------------------------------------------------
  typedef logic [31:0] data_word_t;
  typedef logic [24:0] ram_addr_t;
  typedef logic [23:0] flash_addr_t;
  typedef logic [7:0]  flash_byte_t;
  typedef logic [16:0] page_count_t;

  // One boot word headed for RAM
  typedef struct packed {
    ram_addr_t  addr;
    data_word_t data;
  } ram_wr_t;

  // Single word host access
  typedef struct packed {
    logic       write;
    ram_addr_t  addr;
    data_word_t wdata;
  } host_req_t;

  // Controller local bus request side
  typedef struct packed {
    logic       write_req;
    logic       read_req;
    logic       burstbegin;
    ram_addr_t  address;
    data_word_t wdata;
  } local_cmd_t;

  //--------------------------------------------------------------------------
  // Flash constants
  //--------------------------------------------------------------------------
  // Byte address of a flash page is the page number shifted by this
  localparam int FLASH_PAGE_SHIFT = 8;
  localparam int BYTES_PER_WORD   = 4;

  localparam flash_byte_t FLASH_READ_OP = 8'h03;

endpackage

`default_nettype wire

// ==== logic/spi_flash_reader.sv ====
`default_nettype none

module spi_flash_reader import mem_pkg::*; #(
  parameter int SCK_DIV = 2
) (
  input  wire              phy_clk,
  input  wire              arst_n,
  input  wire              read_start,
  input  wire flash_addr_t read_addr,
  input  wire [11:0]       byte_count,
  input  wire              byte_ready,
  input  wire              flash_dq1,
  output logic             reader_idle,
  output logic             byte_valid,
  output flash_byte_t      byte_data,
  output logic             flash_c,
  output logic             flash_sb,
  output logic             flash_dq0
);

  localparam int DIV_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCK_DIV - 1);

  typedef enum logic [1:0] {st_idle, st_command, st_data, st_done} state_t;

  state_t           state;
  logic [DIV_W-1:0] div_cnt;
  logic             sck;
  logic [4:0]       bit_cnt;
  logic [11:0]      bytes_left;
  logic [31:0]      shift_out;
  flash_byte_t      shift_in;
  logic             byte_complete;
  logic             active;
  logic             stall;
  logic             half_tick;
  logic             rise;
  logic             fall;

  assign active = (state == st_command) || (state == st_data);

  // Keep SCK low at a byte boundary while the previous byte is still held
  assign stall = (state == st_data) && !sck && (bit_cnt == 5'd0) &&
                 byte_valid && !byte_ready;

  assign half_tick = active && !stall && (div_cnt == DIV_LAST);
  assign rise      = half_tick && !sck;
  assign fall      = half_tick && sck;

  assign reader_idle = (state == st_idle);
  assign flash_c     = sck;
  assign flash_dq0   = shift_out[31];

  //--------------------------------------------------------------------------
  // SCK half period divider
  //--------------------------------------------------------------------------
  always_ff @(posedge phy_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
    end else if (!active || half_tick) begin
      div_cnt <= '0;
    end else if (!stall) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // Transfer FSM
  //--------------------------------------------------------------------------
  always_ff @(posedge phy_clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= st_idle;
      flash_sb      <= 1'b1;
      sck           <= 1'b0;
      bit_cnt       <= '0;
      bytes_left    <= '0;
      shift_out     <= '0;
      byte_complete <= 1'b0;
    end else begin
      byte_complete <= 1'b0;
      case (state)
        st_idle: begin
          if (read_start) begin
            state      <= st_command;
            flash_sb   <= 1'b0;
            shift_out  <= {FLASH_READ_OP, read_addr};
            bytes_left <= byte_count;
            bit_cnt    <= '0;
          end
        end
        st_command: begin
          if (rise) begin
            sck <= 1'b1;
          end
          // Mode 0, next bit goes out on the falling edge
          if (fall) begin
            sck       <= 1'b0;
            shift_out <= {shift_out[30:0], 1'b0};
            bit_cnt   <= bit_cnt + 5'd1;
            if (bit_cnt == 5'd31) begin
              state <= st_data;
            end
          end
        end
        st_data: begin
          if (rise) begin
            sck <= 1'b1;
            if (bit_cnt[2:0] == 3'd7) begin
              byte_complete <= 1'b1;
              bytes_left    <= bytes_left - 12'd1;
            end
          end
          if (fall) begin
            sck     <= 1'b0;
            bit_cnt <= {2'b00, bit_cnt[2:0] + 3'd1};
            if (bit_cnt[2:0] == 3'd7 && bytes_left == 12'd0) begin
              state <= st_done;
            end
          end
        end
        st_done: begin
          flash_sb <= 1'b1;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Receive shifter, sampled on SCK rising edges
  always_ff @(posedge phy_clk) begin
    if (state == st_data && rise) begin
      shift_in <= {shift_in[6:0], flash_dq1};
    end
    if (byte_complete) begin
      byte_data <= shift_in;
    end
  end

  // Holding register handshake
  always_ff @(posedge phy_clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_valid <= 1'b0;
    end else if (byte_complete) begin
      byte_valid <= 1'b1;
    end else if (byte_ready) begin
      byte_valid <= 1'b0;
    end
  end

  // Chip select released whenever no transfer runs
  assert property (@(posedge phy_clk) disable iff (!arst_n)
    (state == st_idle) |-> flash_sb);

endmodule

`default_nettype wire

// ==== logic/boot_loader.sv ====
`default_nettype none

module boot_loader import mem_pkg::*; #(
  parameter int PAGE_WORDS      = 64,
  parameter int FLASH_BASE_PAGE = 2048
) (
  input  wire              phy_clk,
  input  wire              arst_n,
  input  wire              local_init_done,
  input  wire              reader_idle,
  input  wire              byte_valid,
  input  wire flash_byte_t byte_data,
  input  wire              wr_ready,
  output logic             read_start,
  output flash_addr_t      read_addr,
  output logic [11:0]      byte_count,
  output logic             byte_ready,
  output logic             wr_valid,
  output ram_wr_t          wr,
  output logic             boot_done
);

  localparam int IDX_W = $clog2(PAGE_WORDS);
  localparam logic [IDX_W:0] LAST_IDX = (IDX_W + 1)'(PAGE_WORDS - 1);

  typedef enum logic [2:0] {
    st_wait_init,
    st_start_page,
    st_collect,
    st_write_word,
    st_next_page,
    st_done
  } state_t;

  state_t         state;
  page_count_t    page;
  page_count_t    page_total;
  page_count_t    page_next;
  logic [IDX_W:0] word_idx;
  logic [1:0]     byte_idx;
  data_word_t     word_buf;
  logic           header_word;

  assign page_next   = page + 17'd1;
  assign header_word = (page == '0) && (word_idx == '0);

  // Image page p sits at flash page FLASH_BASE_PAGE + p
  assign read_addr  = flash_addr_t'(FLASH_BASE_PAGE + int'(page)) << FLASH_PAGE_SHIFT;
  assign byte_count = 12'(PAGE_WORDS * BYTES_PER_WORD);
  assign byte_ready = (state == st_collect);

  assign wr.addr = (ram_addr_t'(page) << IDX_W) + ram_addr_t'(word_idx);
  assign wr.data = word_buf;

  // Big-endian packing, first byte lands in the top
  always_ff @(posedge phy_clk) begin
    if (byte_ready && byte_valid) begin
      word_buf <= {word_buf[23:0], byte_data};
    end
  end

  //--------------------------------------------------------------------------
  // Page loop
  //--------------------------------------------------------------------------
  always_ff @(posedge phy_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_wait_init;
      read_start <= 1'b0;
      wr_valid   <= 1'b0;
      boot_done  <= 1'b0;
      page       <= '0;
      page_total <= 17'd1;
      word_idx   <= '0;
      byte_idx   <= '0;
    end else begin
      read_start <= 1'b0;
      case (state)
        st_wait_init: begin
          if (local_init_done) begin
            state <= st_start_page;
          end
        end
        st_start_page: begin
          if (reader_idle) begin
            read_start <= 1'b1;
            word_idx   <= '0;
            byte_idx   <= '0;
            state      <= st_collect;
          end
        end
        st_collect: begin
          if (byte_valid) begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) begin
              wr_valid <= 1'b1;
              state    <= st_write_word;
            end
          end
        end
        st_write_word: begin
          if (wr_ready) begin
            wr_valid <= 1'b0;
            // Header word, a zero count still means one page
            if (header_word) begin
              page_total <= (word_buf[15:0] == 16'd0) ? 17'd1 : {1'b0, word_buf[15:0]};
            end
            word_idx <= word_idx + 1'b1;
            state    <= (word_idx == LAST_IDX) ? st_next_page : st_collect;
          end
        end
        st_next_page: begin
          page <= page_next;
          if (page_next == page_total) begin
            boot_done <= 1'b1;
            state     <= st_done;
          end else begin
            state <= st_start_page;
          end
        end
        st_done: state <= st_done;
        default: state <= st_wait_init;
      endcase
    end
  end

  assert property (@(posedge phy_clk) disable iff (!arst_n)
    (state == st_collect) |-> (word_idx < PAGE_WORDS));

  // A raised word request waits unchanged for the bus master
  assert property (@(posedge phy_clk) disable iff (!arst_n)
    (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr)));

endmodule

`default_nettype wire

// ==== logic/local_bus_master.sv ====
`default_nettype none

module local_bus_master import mem_pkg::*; (
  input  wire             phy_clk,
  input  wire             arst_n,
  input  wire             boot_done,
  input  wire             wr_valid,
  input  wire ram_wr_t    wr,
  input  wire             req_valid,
  input  wire host_req_t  req,
  input  wire             local_ready,
  input  wire data_word_t local_rdata,
  input  wire             local_rdata_valid,
  output logic            wr_ready,
  output logic            req_ready,
  output logic            rsp_valid,
  output data_word_t      rsp_data,
  output local_cmd_t      local_cmd
);

  typedef enum logic [1:0] {st_idle, st_issue, st_wait_write, st_wait_read} state_t;

  state_t     state;
  logic       op_write;
  ram_addr_t  op_addr;
  data_word_t op_wdata;
  logic       fire;

  // Boot writes own the bus until boot_done, the host after
  assign wr_ready  = (state == st_idle) && !boot_done;
  assign req_ready = (state == st_idle) && boot_done;

  // Command pulse on the first issue cycle the controller is ready
  assign fire = (state == st_issue) && local_ready;

  assign local_cmd = '{
    write_req:  fire && op_write,
    read_req:   fire && !op_write,
    burstbegin: fire,
    address:    op_addr,
    wdata:      op_wdata
  };

  always_ff @(posedge phy_clk) begin
    if (wr_valid && wr_ready) begin
      op_addr  <= wr.addr;
      op_wdata <= wr.data;
    end else if (req_valid && req_ready) begin
      op_addr  <= req.addr;
      op_wdata <= req.wdata;
    end
    if (state == st_wait_read && local_rdata_valid) begin
      rsp_data <= local_rdata;
    end
  end

  //--------------------------------------------------------------------------
  // One operation in flight at a time
  //--------------------------------------------------------------------------
  always_ff @(posedge phy_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      op_write  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (wr_valid && wr_ready) begin
            op_write <= 1'b1;
            state    <= st_issue;
          end else if (req_valid && req_ready) begin
            op_write <= req.write;
            state    <= st_issue;
          end
        end
        st_issue: begin
          if (local_ready) begin
            state <= op_write ? st_wait_write : st_wait_read;
          end
        end
        st_wait_write: begin
          if (local_ready) begin
            state <= st_idle;
          end
        end
        st_wait_read: begin
          if (local_rdata_valid) begin
            rsp_valid <= 1'b1;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assert property (@(posedge phy_clk) disable iff (!arst_n)
    !(local_cmd.write_req && local_cmd.read_req));

  assert property (@(posedge phy_clk) disable iff (!arst_n)
    (local_cmd.write_req || local_cmd.read_req) |-> local_ready);

endmodule

`default_nettype wire

// ==== logic/memory_top.sv ====
`default_nettype none

module memory_top import mem_pkg::*; #(
  parameter int PAGE_WORDS      = 64,
  parameter int FLASH_BASE_PAGE = 2048,
  parameter int SCK_DIV         = 2
) (
  input  wire             phy_clk,
  input  wire             arst_n,

  // Host request and response
  input  wire             req_valid,
  input  wire host_req_t  req,
  output logic            req_ready,
  output logic            rsp_valid,
  output data_word_t      rsp_data,

  // RAM controller local bus
  output local_cmd_t      local_cmd,
  input  wire             local_ready,
  input  wire data_word_t local_rdata,
  input  wire             local_rdata_valid,
  input  wire             local_init_done,
  output logic            boot_done,

  // Serial boot flash
  output logic            flash_c,
  output logic            flash_sb,
  output logic            flash_dq0,
  input  wire             flash_dq1
);

  //--------------------------------------------------------------------------
  // Internal links
  //--------------------------------------------------------------------------
  logic        read_start;
  flash_addr_t read_addr;
  logic [11:0] byte_count;
  logic        reader_idle;
  logic        byte_valid;
  flash_byte_t byte_data;
  logic        byte_ready;
  logic        wr_valid;
  ram_wr_t     wr;
  logic        wr_ready;

  spi_flash_reader #(
    .SCK_DIV (SCK_DIV)
  ) u_reader (
    .phy_clk     (phy_clk),
    .arst_n      (arst_n),
    .read_start  (read_start),
    .read_addr   (read_addr),
    .byte_count  (byte_count),
    .byte_ready  (byte_ready),
    .flash_dq1   (flash_dq1),
    .reader_idle (reader_idle),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .flash_c     (flash_c),
    .flash_sb    (flash_sb),
    .flash_dq0   (flash_dq0)
  );

  boot_loader #(
    .PAGE_WORDS      (PAGE_WORDS),
    .FLASH_BASE_PAGE (FLASH_BASE_PAGE)
  ) u_boot (
    .phy_clk         (phy_clk),
    .arst_n          (arst_n),
    .local_init_done (local_init_done),
    .reader_idle     (reader_idle),
    .byte_valid      (byte_valid),
    .byte_data       (byte_data),
    .wr_ready        (wr_ready),
    .read_start      (read_start),
    .read_addr       (read_addr),
    .byte_count      (byte_count),
    .byte_ready      (byte_ready),
    .wr_valid        (wr_valid),
    .wr              (wr),
    .boot_done       (boot_done)
  );

  local_bus_master u_bus (
    .phy_clk           (phy_clk),
    .arst_n            (arst_n),
    .boot_done         (boot_done),
    .wr_valid          (wr_valid),
    .wr                (wr),
    .req_valid         (req_valid),
    .req               (req),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .wr_ready          (wr_ready),
    .req_ready         (req_ready),
    .rsp_valid         (rsp_valid),
    .rsp_data          (rsp_data),
    .local_cmd         (local_cmd)
  );

endmodule

`default_nettype wire

// ==== testbench/spi_flash_model.sv ====
`default_nettype none

module spi_flash_model #(
  parameter int BASE_ADDR = 'h080000,
  parameter int SIZE      = 768
) (
  input  wire  flash_c,
  input  wire  flash_sb,
  input  wire  flash_dq0,
  output logic flash_dq1
);

  localparam int LOG_DEPTH = 8;

  logic [7:0]  mem [SIZE];
  logic [31:0] cmd_log [LOG_DEPTH];
  int          cmd_count;
  int          select_count;
  logic [31:0] cmd_shift;
  logic [23:0] rd_addr;
  int          bits_in;
  int          bits_out;

  // Addresses outside the image read as erased
  function automatic logic read_bit(input logic [23:0] addr, input int bit_pos);
    int offset;
    offset = int'(addr) - BASE_ADDR;
    if (offset < 0 || offset >= SIZE) begin
      return 1'b1;
    end
    return mem[offset][bit_pos];
  endfunction

  initial begin
    flash_dq1    = 1'b0;
    cmd_count    = 0;
    select_count = 0;
    bits_in      = 0;
    bits_out     = 0;
    cmd_shift    = '0;
    rd_addr      = '0;
  end

  // Each select starts a new command
  always @(negedge flash_sb) begin
    select_count = select_count + 1;
    bits_in      = 0;
    bits_out     = 0;
  end

  // Opcode and address, MSB first on rising SCK
  always @(posedge flash_c) begin
    if (!flash_sb && bits_in < 32) begin
      cmd_shift = {cmd_shift[30:0], flash_dq0};
      bits_in   = bits_in + 1;
      if (bits_in == 32) begin
        if (cmd_count < LOG_DEPTH) begin
          cmd_log[cmd_count] = cmd_shift;
        end
        cmd_count = cmd_count + 1;
        rd_addr   = cmd_shift[23:0];
      end
    end
  end

  // Mode 0 data out on falling SCK
  always @(negedge flash_c) begin
    if (!flash_sb && bits_in == 32) begin
      flash_dq1 <= read_bit(rd_addr + 24'(bits_out / 8), 7 - (bits_out % 8));
      bits_out = bits_out + 1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_memory.sv ====
`default_nettype none

module tb_memory import mem_pkg::*;;

  localparam int PAGE_WORDS      = 64;
  localparam int FLASH_BASE_PAGE = 2048;
  localparam int SCK_DIV         = 2;
  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int IMAGE_PAGES     = 3;
  localparam int IMAGE_WORDS     = IMAGE_PAGES * PAGE_WORDS;
  localparam int IMAGE_BYTES     = IMAGE_WORDS * 4;
  localparam int NUM_READS       = 16;
  localparam int NUM_WRITES      = 12;
  localparam int OP_TIMEOUT      = 64;
  localparam logic [7:0] FLASH_READ = 8'h03;

  // Serial time per page plus slack for RAM writes
  localparam int BOOT_CYCLES = IMAGE_PAGES * (32 + PAGE_WORDS * 32) * 2 * SCK_DIV +
                               IMAGE_WORDS * 16 + 200;
  localparam int HOST_CYCLES = (NUM_READS + 2 * NUM_WRITES) * OP_TIMEOUT;
  localparam int WATCHDOG_CYCLES = 2 * BOOT_CYCLES + HOST_CYCLES + RESET_CYCLES + 100;

  logic       phy_clk;
  logic       arst_n;
  logic       req_valid;
  host_req_t  req;
  logic       req_ready;
  logic       rsp_valid;
  data_word_t rsp_data;
  local_cmd_t local_cmd;
  logic       local_ready;
  data_word_t local_rdata;
  logic       local_rdata_valid;
  logic       local_init_done;
  logic       boot_done;
  logic       flash_c;
  logic       flash_sb;
  logic       flash_dq0;
  logic       flash_dq1;

  int         seed = 32'he849;
  logic [7:0] image [IMAGE_BYTES];
  data_word_t ram [ram_addr_t];
  ram_addr_t  boot_addr_log[$];
  data_word_t boot_data_log[$];
  data_word_t rsp_expect[$];
  int         rsp_seen;
  logic       host_phase;
  logic       early_ready;
  int         error_count;
  int         check_count;
  int         test_count;
  int         failed_tests;
  string      cur_test;

  memory_top #(
    .PAGE_WORDS      (PAGE_WORDS),
    .FLASH_BASE_PAGE (FLASH_BASE_PAGE),
    .SCK_DIV         (SCK_DIV)
  ) DUT (
    .phy_clk           (phy_clk),
    .arst_n            (arst_n),
    .req_valid         (req_valid),
    .req               (req),
    .req_ready         (req_ready),
    .rsp_valid         (rsp_valid),
    .rsp_data          (rsp_data),
    .local_cmd         (local_cmd),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .local_init_done   (local_init_done),
    .boot_done         (boot_done),
    .flash_c           (flash_c),
    .flash_sb          (flash_sb),
    .flash_dq0         (flash_dq0),
    .flash_dq1         (flash_dq1)
  );

  spi_flash_model #(
    .BASE_ADDR (FLASH_BASE_PAGE * 256),
    .SIZE      (IMAGE_BYTES)
  ) u_flash (
    .flash_c   (flash_c),
    .flash_sb  (flash_sb),
    .flash_dq0 (flash_dq0),
    .flash_dq1 (flash_dq1)
  );

  //--------------------------------------------------------------------------
  // Reference and bookkeeping
  //--------------------------------------------------------------------------
  // Big-endian word from the image bytes
  function automatic data_word_t expected_word(input int page, input int index);
    int base;
    base = (page * PAGE_WORDS + index) * 4;
    return {image[base], image[base + 1], image[base + 2], image[base + 3]};
  endfunction

  task automatic compare_values(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s %s expected %0h actual %0h", cur_test, name, expected, actual);
    end
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("ERROR in %s, %s", cur_test, what);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s ok", name);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  //--------------------------------------------------------------------------
  // Host channel
  //--------------------------------------------------------------------------
  task automatic host_request(input logic is_write, input ram_addr_t addr,
                              input data_word_t wdata);
    int waited;
    waited = 0;
    @(negedge phy_clk);
    req_valid = 1'b1;
    req       = '{write: is_write, addr: addr, wdata: wdata};
    while (!req_ready && waited < OP_TIMEOUT) begin
      @(negedge phy_clk);
      waited++;
    end
    if (!req_ready) begin
      note_failure("host request was not accepted in time");
    end
    @(negedge phy_clk);
    req_valid = 1'b0;
  endtask

  // Write ends when req_ready comes back
  task automatic host_write(input ram_addr_t addr, input data_word_t wdata);
    int waited;
    waited = 0;
    host_request(1'b1, addr, wdata);
    while (!req_ready && waited < OP_TIMEOUT) begin
      @(negedge phy_clk);
      waited++;
    end
    if (!req_ready) begin
      note_failure("host write did not complete in time");
    end
  endtask

  task automatic host_read(input ram_addr_t addr, input data_word_t expected);
    int waited;
    int seen;
    waited = 0;
    seen   = rsp_seen;
    rsp_expect.push_back(expected);
    host_request(1'b0, addr, '0);
    while (rsp_seen == seen && waited < OP_TIMEOUT) begin
      @(negedge phy_clk);
      waited++;
    end
    if (rsp_seen == seen) begin
      note_failure("no read response arrived in time");
    end
  endtask

  //--------------------------------------------------------------------------
  // Clock, watchdog, monitors
  //--------------------------------------------------------------------------
  initial begin
    phy_clk = 1'b0;
    forever #(CLK_PERIOD / 2) phy_clk = ~phy_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR watchdog expired at %0t, the run is stopped", $time);
    $display("Result: FAILED");
    $finish;
  end

  always @(negedge phy_clk) begin
    if (arst_n && req_ready && !boot_done) begin
      early_ready = 1'b1;
    end
  end

  // Response compare
  always @(negedge phy_clk) begin
    if (rsp_valid) begin
      if (rsp_expect.size() == 0) begin
        note_failure("read response without a pending read");
      end else begin
        compare_values("read_data", 64'(rsp_expect.pop_front()), 64'(rsp_data));
      end
      rsp_seen++;
    end
  end

  //--------------------------------------------------------------------------
  // RAM controller model
  //--------------------------------------------------------------------------
  initial begin : ram_model
    local_cmd_t cmd_seen;
    ram_addr_t  rd_addr;
    logic       rd_pending;
    int         rd_delay;
    cmd_seen   = '0;
    rd_addr    = '0;
    rd_pending = 1'b0;
    rd_delay   = 0;
    forever begin
      @(negedge phy_clk);
      local_rdata_valid = 1'b0;
      if (rd_pending) begin
        if (rd_delay == 0) begin
          local_rdata_valid = 1'b1;
          local_rdata       = ram.exists(rd_addr) ? ram[rd_addr] : '0;
          rd_pending        = 1'b0;
        end else begin
          rd_delay--;
        end
      end
      // Command taken at the last rising edge
      if (cmd_seen.write_req || cmd_seen.read_req || cmd_seen.burstbegin) begin
        compare_values("burstbegin", 64'(cmd_seen.write_req || cmd_seen.read_req),
                       64'(cmd_seen.burstbegin));
      end
      if (cmd_seen.write_req) begin
        ram[cmd_seen.address] = cmd_seen.wdata;
        if (!host_phase) begin
          boot_addr_log.push_back(cmd_seen.address);
          boot_data_log.push_back(cmd_seen.wdata);
        end
      end
      if (cmd_seen.read_req) begin
        rd_pending = 1'b1;
        rd_addr    = cmd_seen.address;
        rd_delay   = $unsigned($random(seed)) % 4;
      end
      local_ready = ($unsigned($random(seed)) % 4) != 0;
      // Settled command for the next rising edge
      #(CLK_PERIOD / 4);
      cmd_seen = local_cmd;
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin : main
    int         errors_before;
    int         waited;
    int         idx;
    ram_addr_t  addr;
    data_word_t data;
    logic       boot_ok;
    arst_n            = 1'b0;
    req_valid         = 1'b0;
    req               = '0;
    local_ready       = 1'b0;
    local_rdata       = '0;
    local_rdata_valid = 1'b0;
    local_init_done   = 1'b0;
    host_phase        = 1'b0;
    early_ready       = 1'b0;
    rsp_seen          = 0;
    error_count       = 0;
    check_count       = 0;
    test_count        = 0;
    failed_tests      = 0;
    boot_ok           = 1'b0;

    // Random image whose header gives three pages
    for (int i = 0; i < IMAGE_BYTES; i++) begin
      image[i] = 8'($random(seed));
    end
    image[2] = 8'h00;
    image[3] = 8'(IMAGE_PAGES);
    for (int i = 0; i < IMAGE_BYTES; i++) begin
      u_flash.mem[i] = image[i];
    end

    cur_test      = "boot_gate";
    errors_before = error_count;
    repeat (RESET_CYCLES) @(negedge phy_clk);
    compare_values("reset_req_ready", 64'(0), 64'(req_ready));
    compare_values("reset_rsp_valid", 64'(0), 64'(rsp_valid));
    compare_values("reset_boot_done", 64'(0), 64'(boot_done));
    compare_values("reset_write_req", 64'(0), 64'(local_cmd.write_req));
    compare_values("reset_read_req", 64'(0), 64'(local_cmd.read_req));
    compare_values("reset_burstbegin", 64'(0), 64'(local_cmd.burstbegin));
    compare_values("reset_flash_sb", 64'(1), 64'(flash_sb));
    arst_n = 1'b1;
    repeat (8) @(negedge phy_clk);
    local_init_done = 1'b1;

    waited = 0;
    while (!boot_done && waited < 2 * BOOT_CYCLES) begin
      @(negedge phy_clk);
      waited++;
    end
    boot_ok = boot_done;
    if (!boot_ok) begin
      note_failure("boot_done never rose");
    end
    // Bus idle means the last boot write is done
    waited = 0;
    while (!req_ready && waited < OP_TIMEOUT) begin
      @(negedge phy_clk);
      waited++;
    end
    if (boot_ok && !req_ready) begin
      note_failure("req_ready did not rise after boot");
    end
    compare_values("req_ready_before_boot", 64'(0), 64'(early_ready));
    host_phase = 1'b1;
    finish_test(cur_test, errors_before);

    cur_test      = "boot_writes";
    errors_before = error_count;
    compare_values("boot_write_count", 64'(IMAGE_WORDS), 64'(boot_addr_log.size()));
    for (int n = 0; n < boot_addr_log.size() && n < IMAGE_WORDS; n++) begin
      compare_values("boot_write_addr", 64'(n), 64'(boot_addr_log[n]));
      compare_values("boot_write_data", 64'(expected_word(n / PAGE_WORDS, n % PAGE_WORDS)),
                     64'(boot_data_log[n]));
    end
    finish_test(cur_test, errors_before);

    cur_test      = "flash_reads";
    errors_before = error_count;
    compare_values("flash_selects", 64'(IMAGE_PAGES), 64'(u_flash.select_count));
    compare_values("flash_commands", 64'(IMAGE_PAGES), 64'(u_flash.cmd_count));
    for (int p = 0; p < IMAGE_PAGES && p < u_flash.cmd_count; p++) begin
      compare_values("flash_command", 64'({FLASH_READ, 24'((FLASH_BASE_PAGE + p) * 256)}),
                     64'(u_flash.cmd_log[p]));
    end
    compare_values("flash_sb_after_boot", 64'(1), 64'(flash_sb));
    finish_test(cur_test, errors_before);

    if (boot_ok) begin
      cur_test      = "host_read";
      errors_before = error_count;
      for (int i = 0; i < NUM_READS; i++) begin
        idx = $unsigned($random(seed)) % IMAGE_WORDS;
        host_read(ram_addr_t'(idx), expected_word(idx / PAGE_WORDS, idx % PAGE_WORDS));
      end
      finish_test(cur_test, errors_before);

      // Addresses above the image while local_ready keeps dropping at random
      cur_test      = "host_write_read";
      errors_before = error_count;
      for (int i = 0; i < NUM_WRITES; i++) begin
        idx  = $unsigned($random(seed)) % 4096;
        addr = ram_addr_t'(IMAGE_WORDS + idx);
        data = $random(seed);
        host_write(addr, data);
        host_read(addr, data);
      end
      finish_test(cur_test, errors_before);
    end else begin
      note_failure("host tests skipped since boot did not finish");
    end

    repeat (4) @(negedge phy_clk);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/mem_pkg.sv
logic/spi_flash_reader.sv
logic/boot_loader.sv
logic/local_bus_master.sv
logic/memory_top.sv
testbench/spi_flash_model.sv
testbench/tb_memory.sv

// ==== Makefile ====
# Verilator build and run of the memory front end testbench

VERILATOR ?= verilator
TOP       ?= tb_memory
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
